// File: tb.f
+incdir+common
common/bus_fabric_pkg.sv
design/master_arbiter.sv
design/sram_port.sv
design/bus_return.sv
design/bus_fabric_top.sv
dv/tb_bus_fabric.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the bus fabric testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "Cannot enter the project directory"
    exit 1
fi

verilator --binary --timing --assert -j 0 \
    --top-module tb_bus_fabric -f tb.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_bus_fabric)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Finished with no errors"; then
    exit 0
fi
exit 1

// File: dv/tb_bus_fabric.sv
`default_nettype none

module tb_bus_fabric;
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] base_win = 32'h8000_0000;
    localparam logic [31:0] ext_win  = 32'h8040_0000;
    localparam int num_random = 200;
    localparam int cycle_limit = 5000;  // About 420 accesses at up to 10 cycles under contention

    logic        sys_clk = 1'b0;
    logic        sys_rst;
    logic        inst_cyc_i, inst_stb_i, inst_we_i, inst_ack_o, inst_err_o;
    logic [31:0] inst_adr_i, inst_dat_i, inst_dat_o;
    logic [3:0]  inst_sel_i;
    logic        data_cyc_i, data_stb_i, data_we_i, data_ack_o, data_err_o;
    logic [31:0] data_adr_i, data_dat_i, data_dat_o;
    logic [3:0]  data_sel_i;
    logic [19:0] base_ram_addr_o, ext_ram_addr_o;
    logic [31:0] base_ram_dq_i, base_ram_dq_o, ext_ram_dq_i, ext_ram_dq_o;
    logic        base_ram_dq_oe_o, base_ram_ce_n_o, base_ram_oe_n_o, base_ram_we_n_o;
    logic        ext_ram_dq_oe_o, ext_ram_ce_n_o, ext_ram_oe_n_o, ext_ram_we_n_o;
    logic [3:0]  base_ram_be_n_o, ext_ram_be_n_o;

    logic [31:0] chip_mem [2][1048576];  // Index 0 is BaseRAM
    logic [31:0] model [logic [31:0]];   // Expected contents, keyed by word-aligned address
    logic [31:0] rng_state;
    int errors, proto_errors, checks, cycles, pin_activity;
    int inst_issued, data_issued, inst_resp, data_resp;

    bus_fabric_top DUT (.*);

    always #20 sys_clk = ~sys_clk;

    always @(posedge sys_clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles, the test did not complete", cycles);
            $display("Finished with errors");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Power-up content of a word, unique per chip and word address
    function automatic logic [31:0] fill_word(input logic [1:0] chip, input logic [19:0] word);
        return {4'hB, 2'b00, chip, 4'h5, word};
    endfunction

    function automatic logic [1:0] window_of(input logic [31:0] adr);
        if ((adr & 32'hFFC0_0000) == base_win)
            return 2'd0;
        if ((adr & 32'hFFC0_0000) == ext_win)
            return 2'd1;
        return 2'd2;  // Unmapped
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
            input logic [31:0] wdat, input logic [3:0] sel);
        logic [31:0] res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (sel[b])
                res[8*b +: 8] = wdat[8*b +: 8];
        end
        return res;
    endfunction

    function automatic logic [31:0] keep_lanes(input logic [31:0] w, input logic [3:0] be_n);
        logic [31:0] res;
        res = 32'h0;
        for (int b = 0; b < 4; b++) begin
            if (!be_n[b])
                res[8*b +: 8] = w[8*b +: 8];
        end
        return res;
    endfunction

    function automatic logic [31:0] expected_word(input logic [31:0] adr);
        logic [31:0] key;
        key = {adr[31:2], 2'b00};
        if (model.exists(key))
            return model[key];
        return fill_word(window_of(adr), adr[21:2]);
    endfunction

    function automatic logic chip_idle(input logic ce_n, input logic oe_n, input logic we_n,
            input logic [3:0] be_n, input logic dq_oe);
        return ce_n && oe_n && we_n && (be_n == 4'hF) && !dq_oe;
    endfunction

    // Chips drive read data while selected with output enable
    assign base_ram_dq_i = (!base_ram_ce_n_o && !base_ram_oe_n_o) ?
        keep_lanes(chip_mem[1'b0][base_ram_addr_o], base_ram_be_n_o) : 32'h0;
    assign ext_ram_dq_i = (!ext_ram_ce_n_o && !ext_ram_oe_n_o) ?
        keep_lanes(chip_mem[1'b1][ext_ram_addr_o], ext_ram_be_n_o) : 32'h0;

    task automatic chip_write(input logic c, input logic [19:0] addr, input logic [31:0] dq,
            input logic dq_oe, input logic ce_n, input logic we_n, input logic [3:0] be_n);
        if (!ce_n && !we_n) begin
            if (!dq_oe) begin
                proto_errors++;
                $display("Write strobe on SRAM %0d while the data bus is not driven", c);
            end
            for (int b = 0; b < 4; b++) begin
                if (!be_n[b])
                    chip_mem[c][addr][8*b +: 8] = dq[8*b +: 8];
            end
        end
    endtask

    // Chip models and bus monitor, all sampled mid-cycle
    initial begin
        for (int a = 0; a < 1048576; a++) begin
            chip_mem[1'b0][a[19:0]] = fill_word(2'd0, a[19:0]);
            chip_mem[1'b1][a[19:0]] = fill_word(2'd1, a[19:0]);
        end
        forever begin
            @(negedge sys_clk);
            chip_write(1'b0, base_ram_addr_o, base_ram_dq_o, base_ram_dq_oe_o,
                base_ram_ce_n_o, base_ram_we_n_o, base_ram_be_n_o);
            chip_write(1'b1, ext_ram_addr_o, ext_ram_dq_o, ext_ram_dq_oe_o,
                ext_ram_ce_n_o, ext_ram_we_n_o, ext_ram_be_n_o);
            if (!chip_idle(base_ram_ce_n_o, base_ram_oe_n_o, base_ram_we_n_o,
                    base_ram_be_n_o, base_ram_dq_oe_o) ||
                !chip_idle(ext_ram_ce_n_o, ext_ram_oe_n_o, ext_ram_we_n_o,
                    ext_ram_be_n_o, ext_ram_dq_oe_o))
                pin_activity++;
            if (inst_ack_o || inst_err_o)
                inst_resp++;
            if (data_ack_o || data_err_o)
                data_resp++;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
            input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
        end
    endtask

    // Holds the request from a falling edge until ack or err
    task automatic bus_access(input logic is_data, input logic we, input logic [31:0] adr,
            input logic [3:0] sel, input logic [31:0] wdat, output logic [31:0] rdat,
            output logic ack, output logic err, output int lat);
        lat = 0;
        ack = 1'b0;
        err = 1'b0;
        rdat = 32'h0;
        if (is_data) begin
            data_we_i  = we;
            data_adr_i = adr;
            data_sel_i = sel;
            data_dat_i = wdat;
            data_cyc_i = 1'b1;
            data_stb_i = 1'b1;
            data_issued++;
        end else begin
            inst_we_i  = we;
            inst_adr_i = adr;
            inst_sel_i = sel;
            inst_dat_i = wdat;
            inst_cyc_i = 1'b1;
            inst_stb_i = 1'b1;
            inst_issued++;
        end
        while (!ack && !err && lat < 64) begin
            @(negedge sys_clk);
            lat++;
            ack  = is_data ? data_ack_o : inst_ack_o;
            err  = is_data ? data_err_o : inst_err_o;
            rdat = is_data ? data_dat_o : inst_dat_o;
        end
        if (is_data) begin
            data_cyc_i = 1'b0;
            data_stb_i = 1'b0;
        end else begin
            inst_cyc_i = 1'b0;
            inst_stb_i = 1'b0;
        end
        if (!ack && !err) begin
            errors++;
            $display("No ack or err for the %s master within 64 cycles",
                is_data ? "data" : "inst");
        end else if (ack && err) begin
            errors++;
            $display("The %s master got ack and err together", is_data ? "data" : "inst");
        end
    endtask

    task automatic run_op(input logic is_data, input logic we, input logic [31:0] adr,
            input logic [3:0] sel, input logic [31:0] wdat, input logic lone);
        string who;
        logic [31:0] rdat;
        logic ack;
        logic err;
        int lat;
        int pins_before;
        who = is_data ? "data" : "inst";
        if (lone)
            @(negedge sys_clk);  // Bus is idle one edge after the previous response
        pins_before = pin_activity;
        bus_access(is_data, we, adr, sel, wdat, rdat, ack, err, lat);
        if ((ack || err) && window_of(adr) != 2'd2) begin
            check_value($sformatf("%s_err_o", who), 32'(err), 32'h0);
            if (lone)
                check_value($sformatf("%s ack latency", who), lat, 4);
            if (we)
                model[{adr[31:2], 2'b00}] = merge_bytes(expected_word(adr), wdat, sel);
            else
                check_value($sformatf("%s_dat_o", who), rdat, expected_word(adr));
        end else if (ack || err) begin
            check_value($sformatf("%s_ack_o", who), 32'(ack), 32'h0);
            if (lone) begin
                check_value($sformatf("%s err latency", who), lat, 2);
                check_value("SRAM pin activity", pin_activity - pins_before, 0);
            end
        end
    endtask

    task automatic window_round(input logic ext);
        logic [31:0] adr;
        logic [31:0] wdat;
        logic [3:0]  sel;
        adr = (ext ? ext_win : base_win) | 32'h0012_3450;
        wdat = xorshift32();
        run_op(1'b1, 1'b1, adr, 4'hF, wdat, 1'b1);
        check_value("chip word at adr[21:2]", chip_mem[ext][adr[21:2]], wdat);
        check_value("other chip word", chip_mem[~ext][adr[21:2]],
            expected_word(adr ^ 32'h0040_0000));
        run_op(1'b0, 1'b0, adr, 4'hF, 32'h0, 1'b1);
        sel = wdat[3:0];
        if (sel == 4'h0 || sel == 4'hF)
            sel = 4'h6;
        run_op(1'b1, 1'b1, adr, sel, xorshift32(), 1'b1);
        run_op(1'b0, 1'b0, adr, 4'hF, 32'h0, 1'b1);
    endtask

    task automatic random_master(input logic is_data, input int count);
        logic [31:0] r;
        logic [31:0] adr;
        logic [3:0]  sel;
        logic        we;
        for (int i = 0; i < count; i++) begin
            r = xorshift32();
            repeat (r[17:16]) @(negedge sys_clk);
            if (r[2:0] == 3'd7) begin
                case (r[5:4])
                    2'd0: adr = 32'h0000_0000;
                    2'd1: adr = 32'h1000_0000;  // Former UART window
                    2'd2: adr = 32'h8080_0000;
                    default: adr = 32'hFFC0_0000;
                endcase
                adr = adr | (r & 32'h003F_FFFC);
            end else begin
                adr = (r[3] ? ext_win : base_win) | {26'h0, r[7:4], 2'b00};
                if (r[8])
                    adr = adr | 32'h003F_FF00;  // Top of the window
            end
            we  = r[9];
            sel = (we && r[10]) ? r[14:11] : 4'hF;
            run_op(is_data, we, adr, sel, xorshift32(), 1'b0);
        end
    endtask

    initial begin
        rng_state = 32'd1103;
        sys_rst = 1'b1;
        inst_cyc_i = 1'b0;
        inst_stb_i = 1'b0;
        inst_we_i = 1'b0;
        inst_adr_i = 32'h0;
        inst_sel_i = 4'h0;
        inst_dat_i = 32'h0;
        data_cyc_i = 1'b0;
        data_stb_i = 1'b0;
        data_we_i = 1'b0;
        data_adr_i = 32'h0;
        data_sel_i = 4'h0;
        data_dat_i = 32'h0;
        repeat (10) @(posedge sys_clk);
        @(negedge sys_clk);
        sys_rst = 1'b0;
        check_value("inst_ack_o", 32'(inst_ack_o), 32'h0);
        check_value("inst_err_o", 32'(inst_err_o), 32'h0);
        check_value("data_ack_o", 32'(data_ack_o), 32'h0);
        check_value("data_err_o", 32'(data_err_o), 32'h0);
        check_value("base_ram pins idle", 32'(chip_idle(base_ram_ce_n_o, base_ram_oe_n_o,
            base_ram_we_n_o, base_ram_be_n_o, base_ram_dq_oe_o)), 32'h1);
        check_value("ext_ram pins idle", 32'(chip_idle(ext_ram_ce_n_o, ext_ram_oe_n_o,
            ext_ram_we_n_o, ext_ram_be_n_o, ext_ram_dq_oe_o)), 32'h1);
        window_round(1'b0);
        window_round(1'b1);
        run_op(1'b1, 1'b1, 32'h1000_0010, 4'hF, 32'hDEAD_BEEF, 1'b1);
        run_op(1'b0, 1'b0, 32'h8080_0000, 4'hF, 32'h0, 1'b1);
        // Both masters in the same cycle
        fork
            run_op(1'b0, 1'b0, ext_win | 32'h40, 4'hF, 32'h0, 1'b0);
            run_op(1'b1, 1'b1, base_win | 32'h40, 4'hF, 32'h1234_5678, 1'b0);
        join
        fork
            random_master(1'b0, num_random);
            random_master(1'b1, num_random);
        join
        repeat (2) @(negedge sys_clk);
        check_value("inst response count", inst_resp, inst_issued);
        check_value("data response count", data_resp, data_issued);
        errors = errors + proto_errors;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: design/bus_fabric_top.sv
`default_nettype none

`include "bus_fabric_macros.svh"

module bus_fabric_top import bus_fabric_pkg::*; (
    input  logic       sys_clk,
    input  logic       sys_rst,
    input  logic       inst_cyc_i,
    input  logic       inst_stb_i,
    input  logic       inst_we_i,
    input  bus_addr_t  inst_adr_i,
    input  bus_sel_t   inst_sel_i,
    input  bus_data_t  inst_dat_i,
    output logic       inst_ack_o,
    output logic       inst_err_o,
    output bus_data_t  inst_dat_o,
    input  logic       data_cyc_i,
    input  logic       data_stb_i,
    input  logic       data_we_i,
    input  bus_addr_t  data_adr_i,
    input  bus_sel_t   data_sel_i,
    input  bus_data_t  data_dat_i,
    output logic       data_ack_o,
    output logic       data_err_o,
    output bus_data_t  data_dat_o,
    output sram_addr_t base_ram_addr_o,
    input  bus_data_t  base_ram_dq_i,
    output bus_data_t  base_ram_dq_o,
    output logic       base_ram_dq_oe_o,
    output logic       base_ram_ce_n_o,
    output logic       base_ram_oe_n_o,
    output logic       base_ram_we_n_o,
    output bus_sel_t   base_ram_be_n_o,
    output sram_addr_t ext_ram_addr_o,
    input  bus_data_t  ext_ram_dq_i,
    output bus_data_t  ext_ram_dq_o,
    output logic       ext_ram_dq_oe_o,
    output logic       ext_ram_ce_n_o,
    output logic       ext_ram_oe_n_o,
    output logic       ext_ram_we_n_o,
    output bus_sel_t   ext_ram_be_n_o
);

    grant_t                       grant;
    slave_vec_t                   slave_stb;
    slave_vec_t                   slave_ack;
    bus_data_t [`BF_NUM_SRAM-1:0] slave_dat;
    logic                         miss_stb;
    logic                         done;
    logic                         bus_we;
    sram_addr_t                   bus_adr;
    bus_sel_t                     bus_sel;
    bus_data_t                    bus_wdat;

    // Chip pins per slave, index 0 is BaseRAM
    sram_addr_t [`BF_NUM_SRAM-1:0] ram_addr;
    bus_data_t [`BF_NUM_SRAM-1:0]  ram_dq_in;
    bus_data_t [`BF_NUM_SRAM-1:0]  ram_dq_out;
    logic [`BF_NUM_SRAM-1:0]       ram_dq_oe;
    logic [`BF_NUM_SRAM-1:0]       ram_ce_n;
    logic [`BF_NUM_SRAM-1:0]       ram_oe_n;
    logic [`BF_NUM_SRAM-1:0]       ram_we_n;
    bus_sel_t [`BF_NUM_SRAM-1:0]   ram_be_n;

    assign ram_dq_in = {ext_ram_dq_i, base_ram_dq_i};
    assign {ext_ram_addr_o, base_ram_addr_o}   = ram_addr;
    assign {ext_ram_dq_o, base_ram_dq_o}       = ram_dq_out;
    assign {ext_ram_dq_oe_o, base_ram_dq_oe_o} = ram_dq_oe;
    assign {ext_ram_ce_n_o, base_ram_ce_n_o}   = ram_ce_n;
    assign {ext_ram_oe_n_o, base_ram_oe_n_o}   = ram_oe_n;
    assign {ext_ram_we_n_o, base_ram_we_n_o}   = ram_we_n;
    assign {ext_ram_be_n_o, base_ram_be_n_o}   = ram_be_n;

    master_arbiter u_arbiter (
        .sys_clk     (sys_clk),
        .sys_rst     (sys_rst),
        .inst_cyc_i  (inst_cyc_i),
        .inst_stb_i  (inst_stb_i),
        .inst_we_i   (inst_we_i),
        .inst_adr_i  (inst_adr_i),
        .inst_sel_i  (inst_sel_i),
        .inst_dat_i  (inst_dat_i),
        .data_cyc_i  (data_cyc_i),
        .data_stb_i  (data_stb_i),
        .data_we_i   (data_we_i),
        .data_adr_i  (data_adr_i),
        .data_sel_i  (data_sel_i),
        .data_dat_i  (data_dat_i),
        .done_i      (done),
        .grant_o     (grant),
        .slave_stb_o (slave_stb),
        .miss_stb_o  (miss_stb),
        .bus_we_o    (bus_we),
        .bus_adr_o   (bus_adr),
        .bus_sel_o   (bus_sel),
        .bus_dat_o   (bus_wdat)
    );

    // One controller per SRAM chip
    for (genvar i = 0; i < `BF_NUM_SRAM; i++) begin : g_sram
        sram_port u_sram_port (
            .sys_clk      (sys_clk),
            .sys_rst      (sys_rst),
            .stb_i        (slave_stb[i]),
            .we_i         (bus_we),
            .adr_i        (bus_adr),
            .sel_i        (bus_sel),
            .dat_i        (bus_wdat),
            .sram_dq_i    (ram_dq_in[i]),
            .ack_o        (slave_ack[i]),
            .dat_o        (slave_dat[i]),
            .sram_addr_o  (ram_addr[i]),
            .sram_dq_o    (ram_dq_out[i]),
            .sram_dq_oe_o (ram_dq_oe[i]),
            .sram_ce_n_o  (ram_ce_n[i]),
            .sram_oe_n_o  (ram_oe_n[i]),
            .sram_we_n_o  (ram_we_n[i]),
            .sram_be_n_o  (ram_be_n[i])
        );
    end

    bus_return u_return (
        .sys_clk     (sys_clk),
        .sys_rst     (sys_rst),
        .grant_i     (grant),
        .slave_ack_i (slave_ack),
        .slave_dat_i (slave_dat),
        .miss_stb_i  (miss_stb),
        .done_o      (done),
        .inst_ack_o  (inst_ack_o),
        .inst_err_o  (inst_err_o),
        .inst_dat_o  (inst_dat_o),
        .data_ack_o  (data_ack_o),
        .data_err_o  (data_err_o),
        .data_dat_o  (data_dat_o)
    );

endmodule

`default_nettype wire

// File: design/bus_return.sv
`default_nettype none

`include "bus_fabric_macros.svh"

module bus_return import bus_fabric_pkg::*; (
    input  logic                         sys_clk,
    input  logic                         sys_rst,
    input  grant_t                       grant_i,
    input  slave_vec_t                   slave_ack_i,
    input  bus_data_t [`BF_NUM_SRAM-1:0] slave_dat_i,
    input  logic                         miss_stb_i,
    output logic                         done_o,
    output logic                         inst_ack_o,
    output logic                         inst_err_o,
    output bus_data_t                    inst_dat_o,
    output logic                         data_ack_o,
    output logic                         data_err_o,
    output bus_data_t                    data_dat_o
);

    logic      err_q;
    logic      ack_any;
    bus_data_t rd_data;

    // One error pulse per miss strobe, the strobe drops right after done
    always_ff @(posedge sys_clk or posedge sys_rst) begin
        if (sys_rst) begin
            err_q <= 1'b0;
        end else begin
            err_q <= miss_stb_i & ~err_q;
        end
    end

    assign ack_any = |slave_ack_i;

    // Read data from whichever slave acks
    always_comb begin
        rd_data = '0;
        for (int i = 0; i < `BF_NUM_SRAM; i++) begin
            if (slave_ack_i[i]) begin
                rd_data = slave_dat_i[i];
            end
        end
    end

    assign done_o = ack_any | err_q;

    assign inst_ack_o = ack_any && (grant_i == grant_inst);
    assign inst_err_o = err_q && (grant_i == grant_inst);
    assign data_ack_o = ack_any && (grant_i == grant_data);
    assign data_err_o = err_q && (grant_i == grant_data);

    assign inst_dat_o = rd_data;
    assign data_dat_o = rd_data;  // Only meaningful with the matching ack

    a_single_ack: assert property (@(posedge sys_clk) disable iff (sys_rst)
        $onehot0(slave_ack_i));

endmodule

`default_nettype wire

// File: design/sram_port.sv
`default_nettype none

module sram_port import bus_fabric_pkg::*; (
    input  logic       sys_clk,
    input  logic       sys_rst,
    input  logic       stb_i,
    input  logic       we_i,
    input  sram_addr_t adr_i,
    input  bus_sel_t   sel_i,
    input  bus_data_t  dat_i,
    input  bus_data_t  sram_dq_i,
    output logic       ack_o,
    output bus_data_t  dat_o,
    output sram_addr_t sram_addr_o,
    output bus_data_t  sram_dq_o,
    output logic       sram_dq_oe_o,
    output logic       sram_ce_n_o,
    output logic       sram_oe_n_o,
    output logic       sram_we_n_o,
    output bus_sel_t   sram_be_n_o
);

    // Cycle counter: 0 idle, 1 and 2 chip selected, 3 ack
    logic [1:0] cnt_q;
    logic       we_q;
    sram_addr_t addr_q;
    bus_sel_t   sel_q;
    bus_data_t  wdata_q;
    bus_data_t  rdata_q;
    logic       start;
    logic       active;

    assign start  = (cnt_q == 2'd0) && stb_i;
    assign active = (cnt_q == 2'd1) || (cnt_q == 2'd2);

    always_ff @(posedge sys_clk or posedge sys_rst) begin
        if (sys_rst) begin
            cnt_q <= 2'd0;
            we_q  <= 1'b0;
        end else if (start) begin
            cnt_q <= 2'd1;
            we_q  <= we_i;
        end else if (cnt_q != 2'd0) begin
            cnt_q <= cnt_q + 2'd1;  // Ack state wraps back to idle
        end
    end

    // Access payload, captured once per cycle
    always_ff @(posedge sys_clk) begin
        if (start) begin
            addr_q  <= adr_i;
            sel_q   <= sel_i;
            wdata_q <= dat_i;
        end
        if ((cnt_q == 2'd2) && !we_q) begin
            rdata_q <= sram_dq_i;  // End of the second read clock
        end
    end

    assign sram_addr_o = addr_q;
    assign sram_dq_o   = wdata_q;
    assign sram_ce_n_o = ~active;
    assign sram_oe_n_o = ~(active & ~we_q);
    assign sram_we_n_o = ~(active & we_q);
    assign sram_be_n_o = active ? ~sel_q : '1;

    // Write data kept on the bus through the ack clock, after we_n rises
    assign sram_dq_oe_o = we_q && (cnt_q != 2'd0);

    assign ack_o = (cnt_q == 2'd3);
    assign dat_o = rdata_q;

    a_oe_we_excl: assert property (@(posedge sys_clk) disable iff (sys_rst)
        !(!sram_oe_n_o && !sram_we_n_o));

    a_no_drive_on_read: assert property (@(posedge sys_clk) disable iff (sys_rst)
        !(sram_dq_oe_o && !sram_oe_n_o));

    // Arbiter keeps the strobe up for the whole chip cycle
    a_stb_held: assert property (@(posedge sys_clk) disable iff (sys_rst)
        (cnt_q != 2'd0) |-> stb_i);

endmodule

`default_nettype wire

// File: design/master_arbiter.sv
`default_nettype none

`include "bus_fabric_macros.svh"

module master_arbiter import bus_fabric_pkg::*; (
    input  logic       sys_clk,
    input  logic       sys_rst,
    input  logic       inst_cyc_i,
    input  logic       inst_stb_i,
    input  logic       inst_we_i,
    input  bus_addr_t  inst_adr_i,
    input  bus_sel_t   inst_sel_i,
    input  bus_data_t  inst_dat_i,
    input  logic       data_cyc_i,
    input  logic       data_stb_i,
    input  logic       data_we_i,
    input  bus_addr_t  data_adr_i,
    input  bus_sel_t   data_sel_i,
    input  bus_data_t  data_dat_i,
    input  logic       done_i,
    output grant_t     grant_o,
    output slave_vec_t slave_stb_o,
    output logic       miss_stb_o,
    output logic       bus_we_o,
    output sram_addr_t bus_adr_o,
    output bus_sel_t   bus_sel_o,
    output bus_data_t  bus_dat_o
);

    // Window bases, indexed like the slave strobes
    localparam bus_addr_t win_base [`BF_NUM_SRAM] = '{`BF_BASE_RAM, `BF_EXT_RAM};

    logic       busy_q;
    grant_t     grant_q;
    slave_vec_t slave_stb_q;
    logic       miss_stb_q;
    logic       req_inst;
    logic       req_data;
    logic       take;
    grant_t     grant_d;
    logic       win_we;
    bus_addr_t  win_adr;
    bus_sel_t   win_sel;
    bus_data_t  win_dat;
    slave_vec_t hit;

    assign req_inst = inst_cyc_i & inst_stb_i;
    assign req_data = data_cyc_i & data_stb_i;
    assign take     = ~busy_q & (req_inst | req_data);
    assign grant_d  = req_data ? grant_data : grant_inst;  // Data port wins a tie

    // Request of the would-be winner
    always_comb begin
        if (grant_d == grant_data) begin
            win_we  = data_we_i;
            win_adr = data_adr_i;
            win_sel = data_sel_i;
            win_dat = data_dat_i;
        end else begin
            win_we  = inst_we_i;
            win_adr = inst_adr_i;
            win_sel = inst_sel_i;
            win_dat = inst_dat_i;
        end
    end

    always_comb begin
        for (int i = 0; i < `BF_NUM_SRAM; i++) begin
            hit[i] = (win_adr & `BF_WIN_MASK) == win_base[i];
        end
    end

    always_ff @(posedge sys_clk or posedge sys_rst) begin
        if (sys_rst) begin
            busy_q      <= 1'b0;
            grant_q     <= grant_inst;
            slave_stb_q <= '0;
            miss_stb_q  <= 1'b0;
        end else if (take) begin
            busy_q      <= 1'b1;
            grant_q     <= grant_d;
            slave_stb_q <= hit;
            miss_stb_q  <= ~|hit;  // Unmapped, error path
        end else if (busy_q && done_i) begin
            busy_q      <= 1'b0;
            slave_stb_q <= '0;
            miss_stb_q  <= 1'b0;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (take) begin
            bus_we_o  <= win_we;
            bus_adr_o <= win_adr[`BF_SRAM_AW+1:2];
            bus_sel_o <= win_sel;
            bus_dat_o <= win_dat;
        end
    end

    assign grant_o     = grant_q;
    assign slave_stb_o = slave_stb_q;
    assign miss_stb_o  = miss_stb_q;

    a_strobe_onehot: assert property (@(posedge sys_clk) disable iff (sys_rst)
        $onehot0({slave_stb_o, miss_stb_o}));

endmodule

`default_nettype wire

// File: common/bus_fabric_pkg.sv
`default_nettype none

`include "bus_fabric_macros.svh"

package bus_fabric_pkg;

    // Bus payload
    typedef logic [`BF_ADDR_W-1:0] bus_addr_t;   // Byte address
    typedef logic [`BF_DATA_W-1:0] bus_data_t;
    typedef logic [`BF_SEL_W-1:0]  bus_sel_t;

    // Word address on the chip, bus address bits 21 down to 2
    typedef logic [`BF_SRAM_AW-1:0] sram_addr_t;

    typedef logic [`BF_NUM_SRAM-1:0] slave_vec_t;  // One bit per SRAM slave

    // Owner of the shared bus
    typedef enum logic {
        grant_inst,
        grant_data
    } grant_t;

endpackage

`default_nettype wire

// File: common/bus_fabric_macros.svh
`ifndef BUS_FABRIC_MACROS_SVH
`define BUS_FABRIC_MACROS_SVH

// Bus payload sizes
`define BF_ADDR_W   32
`define BF_DATA_W   32
`define BF_SEL_W    4   // One select per byte lane

// SRAM chip geometry, word addressed
`define BF_SRAM_AW  20

// Number of SRAM slaves on the fabric
`define BF_NUM_SRAM 2

// Address windows, 4 MiB each
`define BF_BASE_RAM 32'h8000_0000
`define BF_EXT_RAM  32'h8040_0000
`define BF_WIN_MASK 32'hFFC0_0000

`endif
